// ==== verilog/bcam_pkg.sv ====
/* bcam bank shared definitions
   register map, control word bits and configuration address layout */
`default_nettype none

package bcam_pkg;

    //////////////////////////////////////////////////
    // widths

    // config data width, also key and value width
    localparam int REG_WIDTH       = 32;
    localparam int TABLE_SEL_WIDTH = 4;
    localparam int REG_SEL_WIDTH   = 4;

    //////////////////////////////////////////////////
    // register offsets inside one table window

    localparam logic [REG_SEL_WIDTH-1:0] REG_CTRL         = 4'd0;
    localparam logic [REG_SEL_WIDTH-1:0] REG_ENTRY_ID     = 4'd1;
    localparam logic [REG_SEL_WIDTH-1:0] REG_LOOKUP_COUNT = 4'd3;
    localparam logic [REG_SEL_WIDTH-1:0] REG_HIT_COUNT    = 4'd4;
    localparam logic [REG_SEL_WIDTH-1:0] REG_MISS_COUNT   = 4'd5;

    // data window, key then value
    localparam logic [REG_SEL_WIDTH-1:0] REG_KEY          = 4'd8;
    localparam logic [REG_SEL_WIDTH-1:0] REG_VALUE        = 4'd9;

    //////////////////////////////////////////////////
    // control word bits

    localparam int CTRL_RD_BIT     = 0;
    localparam int CTRL_WR_BIT     = 1;
    localparam int CTRL_RST_BIT    = 2;
    // entry valid on WR, read-back status on RD
    localparam int CTRL_IN_USE_BIT = 31;

    //////////////////////////////////////////////////
    // configuration word address

    // flat word address, or table index over register index
    typedef union packed {
        logic [TABLE_SEL_WIDTH+REG_SEL_WIDTH-1:0] raw;
        struct packed {
            logic [TABLE_SEL_WIDTH-1:0] table_sel;
            logic [REG_SEL_WIDTH-1:0]   reg_sel;
        } fields;
    } cfg_addr_u;

endpackage

`default_nettype wire

// ==== verilog/bcam_request_router.sv ====
/* bcam request router
   splits config accesses and lookups into per-table strobes, registers read data */
`default_nettype none

module bcam_request_router #(
    parameter int NUM_TABLES = 4
) (
    input  logic                                  core_clk_ifc,
    input  logic                                  arst_n,

    // configuration port
    input  logic                                  cfg_wr_en,
    input  logic                                  cfg_rd_en,
    input  bcam_pkg::cfg_addr_u                   cfg_addr,
    input  logic [bcam_pkg::REG_WIDTH-1:0]        cfg_wdata,
    output logic [bcam_pkg::REG_WIDTH-1:0]        cfg_rdata,
    output logic                                  cfg_rd_valid,

    // lookup port
    input  logic                                  lookup_valid,
    input  logic [bcam_pkg::TABLE_SEL_WIDTH-1:0]  lookup_table,
    input  logic [bcam_pkg::REG_WIDTH-1:0]        lookup_key,

    // towards the tables
    output logic [NUM_TABLES-1:0]                 tbl_wr_en,
    output logic [bcam_pkg::REG_SEL_WIDTH-1:0]    tbl_reg_sel,
    output logic [bcam_pkg::REG_WIDTH-1:0]        tbl_wdata,
    input  logic [bcam_pkg::REG_WIDTH-1:0]        tbl_rdata [NUM_TABLES],
    output logic [NUM_TABLES-1:0]                 tbl_lookup_en,
    output logic [bcam_pkg::REG_WIDTH-1:0]        tbl_lookup_key
);

    import bcam_pkg::*;

    logic [REG_WIDTH-1:0] rd_word;

    //////////////////////////////////////////////////
    // per-table strobes

    // one-hot decode, indexes past NUM_TABLES select nothing
    always_comb begin
        for (int t = 0; t < NUM_TABLES; t++) begin
            tbl_wr_en[t]     = cfg_wr_en && (cfg_addr.fields.table_sel == t);
            tbl_lookup_en[t] = lookup_valid && (lookup_table == t);
        end
    end

    // shared by all tables, qualified by the strobes
    assign tbl_reg_sel    = cfg_addr.fields.reg_sel;
    assign tbl_wdata      = cfg_wdata;
    assign tbl_lookup_key = lookup_key;

    //////////////////////////////////////////////////
    // read return

    // unmapped table reads as zero
    always_comb begin
        rd_word = '0;
        for (int t = 0; t < NUM_TABLES; t++) begin
            if (cfg_addr.fields.table_sel == t) begin
                rd_word = tbl_rdata[t];
            end
        end
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            cfg_rd_valid <= 1'b0;
        end else begin
            cfg_rd_valid <= cfg_rd_en;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (cfg_rd_en) begin
            cfg_rdata <= rd_word;
        end
    end

    //////////////////////////////////////////////////
    // checks

    // a lookup to a missing table would never produce a result
    lookup_table_in_range : assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n)
        lookup_valid |-> (lookup_table < NUM_TABLES)
    ) else $error("lookup to table %0d, only %0d tables", lookup_table, NUM_TABLES);

    // config port carries one access per cycle
    cfg_single_access : assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n)
        !(cfg_wr_en && cfg_rd_en)
    ) else $error("write and read strobes in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/bcam_table.sv ====
/* bcam table
   exact-match entries with staging registers, CTRL commands, counters and lookup */
`default_nettype none

module bcam_table #(
    parameter  int NUM_ENTRIES = 8,
    localparam int ENTRY_WIDTH = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1
) (
    input  logic                               core_clk_ifc,
    input  logic                               arst_n,

    // register window
    input  logic                               wr_en,
    input  logic [bcam_pkg::REG_SEL_WIDTH-1:0] reg_sel,
    input  logic [bcam_pkg::REG_WIDTH-1:0]     wdata,
    output logic [bcam_pkg::REG_WIDTH-1:0]     rdata,

    // lookup
    input  logic                               lookup_en,
    input  logic [bcam_pkg::REG_WIDTH-1:0]     lookup_key,
    output logic                               res_valid,
    output logic                               res_hit,
    output logic [ENTRY_WIDTH-1:0]             res_entry,
    output logic [bcam_pkg::REG_WIDTH-1:0]     res_value
);

    import bcam_pkg::*;

    // entry storage
    logic [REG_WIDTH-1:0]   entry_key   [NUM_ENTRIES];
    logic [REG_WIDTH-1:0]   entry_value [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] entry_in_use;

    // staging and command registers
    logic [REG_WIDTH-1:0]   stage_key;
    logic [REG_WIDTH-1:0]   stage_value;
    logic [REG_WIDTH-1:0]   entry_id;
    logic [ENTRY_WIDTH-1:0] entry_idx;
    logic                   rd_status;

    logic [REG_WIDTH-1:0]   lookup_count;
    logic [REG_WIDTH-1:0]   hit_count;
    logic [REG_WIDTH-1:0]   miss_count;

    logic                   ctrl_wr;
    logic                   ctrl_rst;
    logic                   match_hit;
    logic [ENTRY_WIDTH-1:0] match_idx;
    logic [REG_WIDTH-1:0]   match_value;

    assign entry_idx = entry_id[ENTRY_WIDTH-1:0];
    assign ctrl_wr   = wr_en && (reg_sel == REG_CTRL);
    assign ctrl_rst  = ctrl_wr && wdata[CTRL_RST_BIT];

    //////////////////////////////////////////////////
    // configuration and counters

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entry_key[i]   <= '0;
                entry_value[i] <= '0;
            end
            entry_in_use <= '0;
            stage_key    <= '0;
            stage_value  <= '0;
            entry_id     <= '0;
            rd_status    <= 1'b0;
            lookup_count <= '0;
            hit_count    <= '0;
            miss_count   <= '0;
        end else if (ctrl_rst) begin
            // RST beats WR and RD, and drops a lookup in the same cycle
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entry_key[i]   <= '0;
                entry_value[i] <= '0;
            end
            entry_in_use <= '0;
            stage_key    <= '0;
            stage_value  <= '0;
            entry_id     <= '0;
            rd_status    <= 1'b0;
            lookup_count <= '0;
            hit_count    <= '0;
            miss_count   <= '0;
        end else begin
            if (wr_en) begin
                case (reg_sel)
                    REG_CTRL: begin
                        if (wdata[CTRL_WR_BIT]) begin
                            // bit 31 clear turns this into a delete
                            entry_key[entry_idx]    <= stage_key;
                            entry_value[entry_idx]  <= stage_value;
                            entry_in_use[entry_idx] <= wdata[CTRL_IN_USE_BIT];
                        end else if (wdata[CTRL_RD_BIT]) begin
                            stage_key   <= entry_key[entry_idx];
                            stage_value <= entry_value[entry_idx];
                            rd_status   <= entry_in_use[entry_idx];
                        end
                    end
                    REG_ENTRY_ID: entry_id    <= wdata;
                    REG_KEY:      stage_key   <= wdata;
                    REG_VALUE:    stage_value <= wdata;
                    default: ;
                endcase
            end
            // counters wrap
            if (lookup_en) begin
                lookup_count <= lookup_count + 1'b1;
                if (match_hit) begin
                    hit_count <= hit_count + 1'b1;
                end else begin
                    miss_count <= miss_count + 1'b1;
                end
            end
        end
    end

    // read mux, unmapped offsets read zero
    always_comb begin
        rdata = '0;
        case (reg_sel)
            REG_CTRL:         rdata[CTRL_IN_USE_BIT] = rd_status;
            REG_ENTRY_ID:     rdata = entry_id;
            REG_LOOKUP_COUNT: rdata = lookup_count;
            REG_HIT_COUNT:    rdata = hit_count;
            REG_MISS_COUNT:   rdata = miss_count;
            REG_KEY:          rdata = stage_key;
            REG_VALUE:        rdata = stage_value;
            default:          rdata = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // match

    // scan downwards so the lowest matching index is kept
    always_comb begin
        match_hit   = 1'b0;
        match_idx   = '0;
        match_value = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (entry_in_use[i] && (entry_key[i] == lookup_key)) begin
                match_hit   = 1'b1;
                match_idx   = ENTRY_WIDTH'(i);
                match_value = entry_value[i];
            end
        end
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= lookup_en;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (lookup_en) begin
            res_hit   <= match_hit;
            res_entry <= match_idx;
            res_value <= match_value;
        end
    end

    // commands act on the stored ENTRY_ID, so it must name a real entry
    entry_id_in_range : assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n)
        (ctrl_wr && (wdata[CTRL_WR_BIT] || wdata[CTRL_RD_BIT])) |-> (entry_id < NUM_ENTRIES)
    ) else $error("ENTRY_ID %0d out of range", entry_id);

endmodule

`default_nettype wire

// ==== verilog/bcam_result_merge.sv ====
/* bcam result merge
   picks the table that reported a result and registers it to the bank outputs */
`default_nettype none

module bcam_result_merge #(
    parameter  int NUM_TABLES  = 4,
    parameter  int NUM_ENTRIES = 8,
    localparam int ENTRY_WIDTH = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1
) (
    input  logic                           core_clk_ifc,
    input  logic                           arst_n,

    // per-table results
    input  logic [NUM_TABLES-1:0]          res_valid,
    input  logic [NUM_TABLES-1:0]          res_hit,
    input  logic [ENTRY_WIDTH-1:0]         res_entry [NUM_TABLES],
    input  logic [bcam_pkg::REG_WIDTH-1:0] res_value [NUM_TABLES],

    // bank result
    output logic                           result_valid,
    output logic                           result_hit,
    output logic [ENTRY_WIDTH-1:0]         result_entry,
    output logic [bcam_pkg::REG_WIDTH-1:0] result_value
);

    import bcam_pkg::*;

    logic                   sel_hit;
    logic [ENTRY_WIDTH-1:0] sel_entry;
    logic [REG_WIDTH-1:0]   sel_value;

    // zero fields when nothing is valid
    always_comb begin
        sel_hit   = 1'b0;
        sel_entry = '0;
        sel_value = '0;
        for (int t = 0; t < NUM_TABLES; t++) begin
            if (res_valid[t]) begin
                sel_hit   = res_hit[t];
                sel_entry = res_entry[t];
                sel_value = res_value[t];
            end
        end
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            result_hit   <= 1'b0;
            result_entry <= '0;
            result_value <= '0;
        end else begin
            result_valid <= |res_valid;
            result_hit   <= sel_hit;
            result_entry <= sel_entry;
            result_value <= sel_value;
        end
    end

    // one lookup per cycle upstream, so one table answers at a time
    single_table_result : assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n)
        $onehot0(res_valid)
    ) else $error("several tables valid at once: %b", res_valid);

endmodule

`default_nettype wire

// ==== verilog/bcam_bank_top.sv ====
/* bcam bank top level
   request router, a row of lookup tables and the result merge */
`default_nettype none

module bcam_bank_top #(
    parameter  int NUM_TABLES  = 4,
    parameter  int NUM_ENTRIES = 8,
    localparam int ENTRY_WIDTH = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1
) (
    input  logic                                 core_clk_ifc,
    input  logic                                 arst_n,

    input  logic                                 cfg_wr_en,
    input  logic                                 cfg_rd_en,
    input  bcam_pkg::cfg_addr_u                  cfg_addr,
    input  logic [bcam_pkg::REG_WIDTH-1:0]       cfg_wdata,
    output logic [bcam_pkg::REG_WIDTH-1:0]       cfg_rdata,
    output logic                                 cfg_rd_valid,

    input  logic                                 lookup_valid,
    input  logic [bcam_pkg::TABLE_SEL_WIDTH-1:0] lookup_table,
    input  logic [bcam_pkg::REG_WIDTH-1:0]       lookup_key,

    output logic                                 result_valid,
    output logic                                 result_hit,
    output logic [ENTRY_WIDTH-1:0]               result_entry,
    output logic [bcam_pkg::REG_WIDTH-1:0]       result_value
);

    import bcam_pkg::*;

    // router to tables
    logic [NUM_TABLES-1:0]    tbl_wr_en;
    logic [REG_SEL_WIDTH-1:0] tbl_reg_sel;
    logic [REG_WIDTH-1:0]     tbl_wdata;
    logic [REG_WIDTH-1:0]     tbl_rdata [NUM_TABLES];
    logic [NUM_TABLES-1:0]    tbl_lookup_en;
    logic [REG_WIDTH-1:0]     tbl_lookup_key;

    // tables to merge
    logic [NUM_TABLES-1:0]    res_valid;
    logic [NUM_TABLES-1:0]    res_hit;
    logic [ENTRY_WIDTH-1:0]   res_entry [NUM_TABLES];
    logic [REG_WIDTH-1:0]     res_value [NUM_TABLES];

    bcam_request_router #(
        .NUM_TABLES     ( NUM_TABLES     )
    ) u_router (
        .core_clk_ifc   ( core_clk_ifc   ),
        .arst_n         ( arst_n         ),
        .cfg_wr_en      ( cfg_wr_en      ),
        .cfg_rd_en      ( cfg_rd_en      ),
        .cfg_addr       ( cfg_addr       ),
        .cfg_wdata      ( cfg_wdata      ),
        .cfg_rdata      ( cfg_rdata      ),
        .cfg_rd_valid   ( cfg_rd_valid   ),
        .lookup_valid   ( lookup_valid   ),
        .lookup_table   ( lookup_table   ),
        .lookup_key     ( lookup_key     ),
        .tbl_wr_en      ( tbl_wr_en      ),
        .tbl_reg_sel    ( tbl_reg_sel    ),
        .tbl_wdata      ( tbl_wdata      ),
        .tbl_rdata      ( tbl_rdata      ),
        .tbl_lookup_en  ( tbl_lookup_en  ),
        .tbl_lookup_key ( tbl_lookup_key )
    );

    for (genvar t = 0; t < NUM_TABLES; t++) begin : gen_table
        bcam_table #(
            .NUM_ENTRIES  ( NUM_ENTRIES      )
        ) u_table (
            .core_clk_ifc ( core_clk_ifc     ),
            .arst_n       ( arst_n           ),
            .wr_en        ( tbl_wr_en[t]     ),
            .reg_sel      ( tbl_reg_sel      ),
            .wdata        ( tbl_wdata        ),
            .rdata        ( tbl_rdata[t]     ),
            .lookup_en    ( tbl_lookup_en[t] ),
            .lookup_key   ( tbl_lookup_key   ),
            .res_valid    ( res_valid[t]     ),
            .res_hit      ( res_hit[t]       ),
            .res_entry    ( res_entry[t]     ),
            .res_value    ( res_value[t]     )
        );
    end

    bcam_result_merge #(
        .NUM_TABLES   ( NUM_TABLES   ),
        .NUM_ENTRIES  ( NUM_ENTRIES  )
    ) u_merge (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .res_valid    ( res_valid    ),
        .res_hit      ( res_hit      ),
        .res_entry    ( res_entry    ),
        .res_value    ( res_value    ),
        .result_valid ( result_valid ),
        .result_hit   ( result_hit   ),
        .result_entry ( result_entry ),
        .result_value ( result_value )
    );

endmodule

`default_nettype wire

// ==== tests/bcam_bank_tests.svh ====
/* bcam bank directed tests
   model upkeep helpers and the test sequences, included into the testbench module */
`ifndef BCAM_BANK_TESTS_SVH
`define BCAM_BANK_TESTS_SVH

//////////////////////////////////////////////////
// model upkeep

task automatic clear_model(input int t);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        model_key[t][i]   = '0;
        model_value[t][i] = '0;
        model_used[t][i]  = 1'b0;
    end
    model_lookups[t] = 0;
    model_hits[t]    = 0;
    model_misses[t]  = 0;
endtask

// stage key and value then commit with WR
task automatic write_entry(input int t, input int idx, input logic [REG_WIDTH-1:0] key,
                           input logic [REG_WIDTH-1:0] value, input logic in_use);
    logic [REG_WIDTH-1:0] ctrl;
    ctrl                  = '0;
    ctrl[CTRL_WR_BIT]     = 1'b1;
    ctrl[CTRL_IN_USE_BIT] = in_use;
    cfg_write(t, REG_KEY, key);
    cfg_write(t, REG_VALUE, value);
    cfg_write(t, REG_ENTRY_ID, idx);
    cfg_write(t, REG_CTRL, ctrl);
    model_key[t][idx]   = key;
    model_value[t][idx] = value;
    model_used[t][idx]  = in_use;
endtask

task automatic reset_table(input int t);
    logic [REG_WIDTH-1:0] ctrl;
    ctrl               = '0;
    ctrl[CTRL_RST_BIT] = 1'b1;
    cfg_write(t, REG_CTRL, ctrl);
    clear_model(t);
endtask

// RD loads the entry into the staging registers
task automatic check_entry(input int t, input int idx);
    logic [REG_WIDTH-1:0] ctrl;
    logic [REG_WIDTH-1:0] status;
    ctrl                    = '0;
    ctrl[CTRL_RD_BIT]       = 1'b1;
    status                  = '0;
    status[CTRL_IN_USE_BIT] = model_used[t][idx];
    cfg_write(t, REG_ENTRY_ID, idx);
    cfg_write(t, REG_CTRL, ctrl);
    cfg_read(t, REG_KEY, model_key[t][idx], "KEY");
    cfg_read(t, REG_VALUE, model_value[t][idx], "VALUE");
    cfg_read(t, REG_CTRL, status, "CTRL");
endtask

task automatic check_counters(input int t);
    cfg_read(t, REG_LOOKUP_COUNT, model_lookups[t], "LOOKUP_COUNT");
    cfg_read(t, REG_HIT_COUNT, model_hits[t], "HIT_COUNT");
    cfg_read(t, REG_MISS_COUNT, model_misses[t], "MISS_COUNT");
endtask

//////////////////////////////////////////////////
// directed tests

task automatic reset_values();
    for (int t = 0; t < NUM_TABLES; t++) begin
        check_counters(t);
        cfg_read(t, REG_KEY, '0, "KEY");
        cfg_read(t, REG_VALUE, '0, "VALUE");
        cfg_read(t, REG_ENTRY_ID, '0, "ENTRY_ID");
    end
    repeat (10) begin
        @(negedge core_clk_ifc);
        if (result_valid) begin
            protocol_errors++;
            $display("result_valid went high with no lookup issued");
        end
    end
endtask

task automatic entry_read_back();
    for (int t = 0; t < NUM_TABLES; t += 2) begin
        for (int i = 0; i < 4; i++) begin
            write_entry(t, i, $random(seed), $random(seed), 1'b1);
        end
    end
    for (int t = 0; t < NUM_TABLES; t += 2) begin
        for (int i = 0; i < 4; i++) begin
            check_entry(t, i);
        end
        // never written
        check_entry(t, NUM_ENTRIES - 1);
    end
endtask

task automatic lookup_stream();
    logic [REG_WIDTH-1:0] key;
    int                   t;
    for (int i = 0; i < 4; i++) begin
        write_entry(1, i + 2, $random(seed), $random(seed), 1'b1);
    end
    // back-to-back lookups cycling over the tables with stored and random keys
    for (int n = 0; n < 24; n++) begin
        t = n % NUM_TABLES;
        if ((n % 3) == 2) begin
            key = $random(seed);
        end else begin
            key = model_key[t][n % 6];
        end
        lookup(t, key);
    end
    wait_results();
    // every real table now counts lookups, so a table index past the bank must read zero
    cfg_read(9, REG_LOOKUP_COUNT, '0, "LOOKUP_COUNT");
    cfg_read(1, 4'd7, '0, "reg 7");
endtask

task automatic counter_totals();
    for (int t = 0; t < NUM_TABLES; t++) begin
        reset_table(t);
    end
    write_entry(1, 0, 32'h0000_1111, 32'haaaa_0001, 1'b1);
    write_entry(1, 3, 32'h0000_2222, 32'haaaa_0002, 1'b1);
    // three hits and two misses on table 1
    lookup(1, 32'h0000_1111);
    lookup(1, 32'h0000_2222);
    lookup(1, 32'h0000_3333);
    lookup(1, 32'h0000_1111);
    lookup(1, 32'h0000_4444);
    wait_results();
    for (int t = 0; t < NUM_TABLES; t++) begin
        check_counters(t);
    end
endtask

task automatic duplicate_key_priority();
    logic [REG_WIDTH-1:0] key;
    key = $random(seed);
    write_entry(2, 5, key, $random(seed), 1'b1);
    write_entry(2, 6, key, $random(seed), 1'b1);
    lookup(2, key);
    // delete the lower copy
    write_entry(2, 5, key, model_value[2][5], 1'b0);
    lookup(2, key);
    wait_results();
endtask

task automatic clear_single_table();
    logic [REG_WIDTH-1:0] key0;
    logic [REG_WIDTH-1:0] key3;
    key0 = $random(seed);
    key3 = $random(seed);
    write_entry(0, 1, key0, $random(seed), 1'b1);
    write_entry(3, 4, key3, $random(seed), 1'b1);
    lookup(0, key0);
    lookup(3, key3);
    wait_results();
    reset_table(0);
    check_counters(0);
    check_entry(0, 1);
    lookup(0, key0);
    lookup(3, key3);
    wait_results();
    check_counters(0);
    check_counters(3);
endtask

`endif

// ==== tests/bcam_bank_tb.sv ====
/* bcam bank testbench
   clock, reset, drivers, table model and result compares around the bank top level */
`default_nettype none

module bcam_bank_tb;

    import bcam_pkg::*;

    localparam int NUM_TABLES  = 4;
    localparam int NUM_ENTRIES = 8;
    localparam int ENTRY_WIDTH = $clog2(NUM_ENTRIES);
    // full sequence runs well under 1500 cycles
    localparam int CYCLE_LIMIT = 3000;

    logic                       core_clk_ifc;
    logic                       arst_n;
    logic                       cfg_wr_en;
    logic                       cfg_rd_en;
    cfg_addr_u                  cfg_addr;
    logic [REG_WIDTH-1:0]       cfg_wdata;
    logic [REG_WIDTH-1:0]       cfg_rdata;
    logic                       cfg_rd_valid;
    logic                       lookup_valid;
    logic [TABLE_SEL_WIDTH-1:0] lookup_table;
    logic [REG_WIDTH-1:0]       lookup_key;
    logic                       result_valid;
    logic                       result_hit;
    logic [ENTRY_WIDTH-1:0]     result_entry;
    logic [REG_WIDTH-1:0]       result_value;

    // reference model of every table
    logic [REG_WIDTH-1:0] model_key   [NUM_TABLES][NUM_ENTRIES];
    logic [REG_WIDTH-1:0] model_value [NUM_TABLES][NUM_ENTRIES];
    logic                 model_used  [NUM_TABLES][NUM_ENTRIES];
    int                   model_lookups [NUM_TABLES];
    int                   model_hits    [NUM_TABLES];
    int                   model_misses  [NUM_TABLES];

    int     checks          = 0;
    int     value_errors    = 0;
    int     protocol_errors = 0;
    int     cycle_count     = 0;
    integer seed;

    bcam_bank_top #(
        .NUM_TABLES   ( NUM_TABLES   ),
        .NUM_ENTRIES  ( NUM_ENTRIES  )
    ) dut (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .cfg_wr_en    ( cfg_wr_en    ),
        .cfg_rd_en    ( cfg_rd_en    ),
        .cfg_addr     ( cfg_addr     ),
        .cfg_wdata    ( cfg_wdata    ),
        .cfg_rdata    ( cfg_rdata    ),
        .cfg_rd_valid ( cfg_rd_valid ),
        .lookup_valid ( lookup_valid ),
        .lookup_table ( lookup_table ),
        .lookup_key   ( lookup_key   ),
        .result_valid ( result_valid ),
        .result_hit   ( result_hit   ),
        .result_entry ( result_entry ),
        .result_value ( result_value )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #2 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, run stopped after %0d cycles", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // compare tasks

    task automatic check_word(input string name, input logic [REG_WIDTH-1:0] got,
                              input logic [REG_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_result(input logic got_hit, input logic [ENTRY_WIDTH-1:0] got_entry,
                                input logic [REG_WIDTH-1:0] got_value, input logic exp_hit,
                                input logic [ENTRY_WIDTH-1:0] exp_entry,
                                input logic [REG_WIDTH-1:0] exp_value);
        checks++;
        if (got_hit !== exp_hit) begin
            value_errors++;
            $display("[FAIL] result_hit got 0x%0h expected 0x%0h", got_hit, exp_hit);
        end
        if (got_entry !== exp_entry) begin
            value_errors++;
            $display("[FAIL] result_entry got 0x%0h expected 0x%0h", got_entry, exp_entry);
        end
        if (got_value !== exp_value) begin
            value_errors++;
            $display("[FAIL] result_value got 0x%08h expected 0x%08h", got_value, exp_value);
        end
    endtask

    //////////////////////////////////////////////////
    // drivers start and end on a falling edge

    function automatic cfg_addr_u make_addr(input int t, input logic [REG_SEL_WIDTH-1:0] r);
        cfg_addr_u a;
        a.fields.table_sel = TABLE_SEL_WIDTH'(t);
        a.fields.reg_sel   = r;
        return a;
    endfunction

    task automatic cfg_write(input int t, input logic [REG_SEL_WIDTH-1:0] r,
                             input logic [REG_WIDTH-1:0] data);
        cfg_addr  = make_addr(t, r);
        cfg_wdata = data;
        cfg_wr_en = 1'b1;
        @(negedge core_clk_ifc);
        cfg_wr_en = 1'b0;
    endtask

    task automatic cfg_read(input int t, input logic [REG_SEL_WIDTH-1:0] r,
                            input logic [REG_WIDTH-1:0] exp, input string name);
        cfg_addr  = make_addr(t, r);
        cfg_rd_en = 1'b1;
        @(negedge core_clk_ifc);
        cfg_rd_en = 1'b0;
        if (!cfg_rd_valid) begin
            protocol_errors++;
            $display("no read response from table %0d register %0d", t, r);
        end else begin
            check_word($sformatf("cfg_rdata table %0d %s", t, name), cfg_rdata, exp);
        end
    endtask

    // lowest in-use entry with an equal key
    task automatic model_match(input int t, input logic [REG_WIDTH-1:0] key,
                               output logic hit, output logic [ENTRY_WIDTH-1:0] entry,
                               output logic [REG_WIDTH-1:0] value);
        hit   = 1'b0;
        entry = '0;
        value = '0;
        for (int i = 0; i < NUM_ENTRIES && !hit; i++) begin
            if (model_used[t][i] && (model_key[t][i] == key)) begin
                hit   = 1'b1;
                entry = ENTRY_WIDTH'(i);
                value = model_value[t][i];
            end
        end
    endtask

    task automatic lookup(input int t, input logic [REG_WIDTH-1:0] key);
        logic                   exp_hit;
        logic [ENTRY_WIDTH-1:0] exp_entry;
        logic [REG_WIDTH-1:0]   exp_value;
        model_match(t, key, exp_hit, exp_entry, exp_value);
        model_lookups[t]++;
        if (exp_hit) begin
            model_hits[t]++;
        end else begin
            model_misses[t]++;
        end
        lookup_valid = 1'b1;
        lookup_table = TABLE_SEL_WIDTH'(t);
        lookup_key   = key;
        fork
            begin : result_check
                int                     e_table = t;
                logic                   e_hit   = exp_hit;
                logic [ENTRY_WIDTH-1:0] e_entry = exp_entry;
                logic [REG_WIDTH-1:0]   e_value = exp_value;
                // result is registered on the second rising edge
                repeat (2) @(posedge core_clk_ifc);
                @(negedge core_clk_ifc);
                if (!result_valid) begin
                    protocol_errors++;
                    $display("no lookup result 2 cycles after a lookup in table %0d", e_table);
                end else begin
                    check_result(result_hit, result_entry, result_value,
                                 e_hit, e_entry, e_value);
                end
            end
        join_none
        @(negedge core_clk_ifc);
        lookup_valid = 1'b0;
    endtask

    task automatic wait_results();
        repeat (2) @(negedge core_clk_ifc);
    endtask

    `include "bcam_bank_tests.svh"

    initial begin
        seed         = 27;
        arst_n       = 1'b0;
        cfg_wr_en    = 1'b0;
        cfg_rd_en    = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        lookup_valid = 1'b0;
        lookup_table = '0;
        lookup_key   = '0;
        for (int t = 0; t < NUM_TABLES; t++) begin
            clear_model(t);
        end
        repeat (8) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        arst_n = 1'b1;
        @(negedge core_clk_ifc);

        reset_values();
        entry_read_back();
        lookup_stream();
        counter_totals();
        duplicate_key_priority();
        clear_single_table();

        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errors, protocol_errors);
        if ((value_errors == 0) && (protocol_errors == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+tests
verilog/bcam_pkg.sv
verilog/bcam_request_router.sv
verilog/bcam_table.sv
verilog/bcam_result_merge.sv
verilog/bcam_bank_top.sv
tests/bcam_bank_tb.sv

// ==== Bender.yml ====
package:
  name: bcam_bank

sources:
  - files:
      - verilog/bcam_pkg.sv
      - verilog/bcam_request_router.sv
      - verilog/bcam_table.sv
      - verilog/bcam_result_merge.sv
      - verilog/bcam_bank_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/bcam_bank_tb.sv
